// ==== Makefile ====
# Verilator regression for the fp16 MAC
TOP := tb_fp_mac
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir $(OBJ) -f fp_mac.f
	@out=$$(./$(OBJ)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(OBJ)

// ==== fp_mac.f ====
+incdir+include
source/fp_mac_pkg.sv
source/fp_lead_norm.sv
source/mac_handshake.sv
source/fp_mul_stage.sv
source/fp_add_stage.sv
source/fp_mac.sv
tests/tb_fp_mac.sv

// ==== source/fp_add_stage.sv ====
//////////////////////////////////////////////////////////////////////
// fp16 add stage, product + c, registers on load_add
// alignment truncates, no guard or sticky bits
// exact cancellation gives +0, exponent underflow gives signed zero
//////////////////////////////////////////////////////////////////////
module fp_add_stage
	import fp_mac_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       load_add,
	input  prod_t      prod,
	input  fp16_t      c_reg,
	input  mac_flags_t mul_flags,
	output fp16_t      result,
	output mac_flags_t flags
);

	localparam int XW = EXP_W + 2;

	logic                 c_zero;
	logic signed [XW-1:0] c_exp;
	logic [SIG_W-1:0]     c_sig;
	// x is the larger magnitude
	logic                 x_is_prod;
	logic                 x_sign;
	logic                 y_sign;
	logic signed [XW-1:0] x_exp;
	logic signed [XW-1:0] y_exp;
	logic signed [XW-1:0] exp_diff;
	logic [SIG_W-1:0]     x_sig;
	logic [SIG_W-1:0]     y_sig;
	logic [SIG_W-1:0]     y_align;
	logic [SIG_W:0]       sum;
	logic [SIG_W-1:0]     add_sig;
	logic signed [XW-1:0] add_exp;
	logic [SIG_W:0]       diff;
	logic [SIG_W-1:0]     norm_sig;
	logic signed [XW-1:0] norm_exp;
	logic                 norm_zero;
	fp16_t                result_next;
	mac_flags_t           flags_next;

	assign c_zero = (c_reg.exp == '0);
	assign c_exp  = XW'(c_reg.exp);
	assign c_sig  = {1'b1, c_reg.mant};

	//////////////////////////////////////////////////////////////////////
	// swap and align
	//////////////////////////////////////////////////////////////////////

	// exponent first, then significand; a tie keeps the product as x
	assign x_is_prod = (prod.exp > c_exp) || ((prod.exp == c_exp) && (prod.sig >= c_sig));

	assign x_exp  = x_is_prod ? prod.exp : c_exp;
	assign y_exp  = x_is_prod ? c_exp : prod.exp;
	assign x_sig  = x_is_prod ? prod.sig : c_sig;
	assign y_sig  = x_is_prod ? c_sig : prod.sig;
	assign x_sign = x_is_prod ? prod.sign : c_reg.sign;
	assign y_sign = x_is_prod ? c_reg.sign : prod.sign;

	assign exp_diff = x_exp - y_exp;
	// shifted out bits are dropped, 12+ leaves nothing
	assign y_align  = y_sig >> exp_diff;

	//////////////////////////////////////////////////////////////////////
	// add and subtract
	//////////////////////////////////////////////////////////////////////

	// carry renormalizes right by one, truncating
	assign sum     = {1'b0, x_sig} + {1'b0, y_align};
	assign add_sig = sum[SIG_W] ? sum[SIG_W:1] : sum[SIG_W-1:0];
	assign add_exp = x_exp + XW'(sum[SIG_W]);

	// never negative since x >= y
	assign diff = {1'b0, x_sig} - {1'b0, y_align};

	fp_lead_norm u_norm (
		.diff    (diff),
		.exp_in  (x_exp),
		.sig     (norm_sig),
		.exp_out (norm_exp),
		.is_zero (norm_zero)
	);

	always_comb begin
		result_next = '0;
		flags_next  = mul_flags;
		if (mul_flags.exception) begin
			// exception result is +0
			result_next = '0;
		end else if (mul_flags.overflow) begin
			// infinite product wins over c
			result_next.sign = prod.sign;
			result_next.exp  = EXP_W'(EXP_MAX);
		end else if (prod.is_zero && c_zero) begin
			result_next.sign = prod.sign;
		end else if (prod.is_zero) begin
			result_next = c_reg;
		end else if (c_zero) begin
			result_next.sign = prod.sign;
			result_next.exp  = prod.exp[EXP_W-1:0];
			result_next.mant = prod.sig[MANT_W-1:0];
		end else if (x_sign == y_sign) begin
			result_next.sign = x_sign;
			if (add_exp >= EXP_MAX) begin
				result_next.exp     = EXP_W'(EXP_MAX);
				flags_next.overflow = 1'b1;
			end else begin
				result_next.exp  = add_exp[EXP_W-1:0];
				result_next.mant = add_sig[MANT_W-1:0];
			end
		end else if (!norm_zero) begin
			// zero difference falls through as +0
			result_next.sign = x_sign;
			if (norm_exp <= 0) begin
				flags_next.underflow = 1'b1;
			end else begin
				result_next.exp  = norm_exp[EXP_W-1:0];
				result_next.mant = norm_sig[MANT_W-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
			flags  <= '0;
		end else if (load_add) begin
			result <= result_next;
			flags  <= flags_next;
		end
	end

	// all-ones exponent only as an overflowed infinity, never a nan pattern
	a_inf_only: assert property (@(posedge clk) disable iff (!arst_n)
		(result.exp == EXP_W'(EXP_MAX)) |-> ((result.mant == '0) && flags.overflow))
		else $error("result exponent 31 without clean overflow infinity");

endmodule

// ==== source/fp_lead_norm.sv ====
//////////////////////////////////////////////////////////////////////
// leading-one normalizer, width follows SIG_W
// top input bit counts as a carry, output exponent may go <= 0
//////////////////////////////////////////////////////////////////////
module fp_lead_norm
	import fp_mac_pkg::*;
(
	input  logic [SIG_W:0]          diff,
	input  logic signed [EXP_W+1:0] exp_in,
	output logic [SIG_W-1:0]        sig,
	output logic signed [EXP_W+1:0] exp_out,
	output logic                    is_zero
);

	localparam int XW   = EXP_W + 2;
	localparam int LZ_W = $clog2(SIG_W + 2);

	// leading zeros over the full SIG_W+1 bits
	logic [LZ_W-1:0] lz;
	logic [SIG_W:0]  shifted;

	always_comb begin
		lz = '0;
		// scan upward so the highest set bit is the last write
		for (int i = 0; i <= SIG_W; i++) begin
			if (diff[i]) lz = LZ_W'(SIG_W - i);
		end
	end

	// leading one lands on the top bit, dropped lsb truncates a carry
	assign shifted = diff << lz;
	assign sig     = shifted[SIG_W:1];

	// lz of 1 means already normal
	assign exp_out = exp_in - XW'(lz) + XW'(1);
	assign is_zero = (diff == '0);

	always_comb begin
		assert (is_zero || sig[SIG_W-1])
			else $error("normalized significand lost its hidden bit");
	end

endmodule

// ==== source/fp_mac.sv ====
//////////////////////////////////////////////////////////////////////
// fp16 multiply-accumulate, result = a * b + c
// four-phase req/ack, one operation in flight at a time
// ack two cycles after req is sampled, result held until ack falls
//////////////////////////////////////////////////////////////////////
module fp_mac
	import fp_mac_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,
	input  logic          req,
	input  mac_operands_t operands,
	output logic          ack,
	output fp16_t         result,
	output mac_flags_t    flags
);

	// stage load strobes
	logic       load_mul;
	logic       load_add;
	// mul -> add stage
	prod_t      prod;
	fp16_t      c_reg;
	mac_flags_t mul_flags;

	mac_handshake u_handshake (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.load_mul (load_mul),
		.load_add (load_add),
		.ack      (ack)
	);

	fp_mul_stage u_mul (
		.clk       (clk),
		.arst_n    (arst_n),
		.load_mul  (load_mul),
		.operands  (operands),
		.prod      (prod),
		.c_reg     (c_reg),
		.mul_flags (mul_flags)
	);

	fp_add_stage u_add (
		.clk       (clk),
		.arst_n    (arst_n),
		.load_add  (load_add),
		.prod      (prod),
		.c_reg     (c_reg),
		.mul_flags (mul_flags),
		.result    (result),
		.flags     (flags)
	);

endmodule

// ==== source/fp_mac_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// half-precision formats shared by the MAC datapath and its model
// widths are fixed here; a format change means editing this package
// exponent 0 encodes zero, exponent 31 is only flagged as exception
//////////////////////////////////////////////////////////////////////
package fp_mac_pkg;

	//////////////////////////////////////////////////////////////////////
	// format constants
	//////////////////////////////////////////////////////////////////////

	// exponent field width
	localparam int EXP_W = 5;
	// stored mantissa, hidden bit not included
	localparam int MANT_W = 10;
	// significand with hidden bit
	localparam int SIG_W = MANT_W + 1;
	localparam int EXP_BIAS = 15;
	// all ones exponent, inf/nan encodings
	localparam int EXP_MAX = (1 << EXP_W) - 1;

	//////////////////////////////////////////////////////////////////////
	// packed types
	//////////////////////////////////////////////////////////////////////

	// operand and result word
	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;
		logic [MANT_W-1:0] mant;
	} fp16_t;

	// result = a * b + c
	typedef struct packed {
		fp16_t a;
		fp16_t b;
		fp16_t c;
	} mac_operands_t;

	// status bits reported with the result
	typedef struct packed {
		logic exception;
		logic overflow;
		logic underflow;
	} mac_flags_t;

	// product between the two stages
	// exp is two bits wider and signed, so excursions past 0 or 31 survive
	typedef struct packed {
		logic                    sign;
		logic                    is_zero;
		logic signed [EXP_W+1:0] exp;
		logic [SIG_W-1:0]        sig;
	} prod_t;

endpackage

// ==== source/fp_mul_stage.sv ====
//////////////////////////////////////////////////////////////////////
// fp16 product stage, registers on load_mul
// exponent 0 reads as zero, no subnormal inputs or outputs
// any exponent 31 among a, b, c gives exception and nothing else
//////////////////////////////////////////////////////////////////////
module fp_mul_stage
	import fp_mac_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,
	input  logic          load_mul,
	input  mac_operands_t operands,
	output prod_t         prod,
	output fp16_t         c_reg,
	output mac_flags_t    mul_flags
);

	localparam int XW = EXP_W + 2;
	localparam int PW = 2 * SIG_W;

	fp16_t                a;
	fp16_t                b;
	logic                 a_zero;
	logic                 b_zero;
	logic                 special;
	logic [SIG_W-1:0]     sig_a;
	logic [SIG_W-1:0]     sig_b;
	logic [PW-1:0]        product;
	logic [PW-1:0]        prod_norm;
	logic                 prod_hi;
	// mantissa plus round carry on top
	logic [MANT_W:0]      mant_rnd;
	logic signed [XW-1:0] exp_calc;
	prod_t                prod_next;
	mac_flags_t           flags_next;

	assign a = operands.a;
	assign b = operands.b;

	// operand classes
	assign a_zero  = (a.exp == '0);
	assign b_zero  = (b.exp == '0);
	assign special = (a.exp == EXP_W'(EXP_MAX)) || (b.exp == EXP_W'(EXP_MAX)) ||
		(operands.c.exp == EXP_W'(EXP_MAX));

	// hidden bit only for non-zero exponent
	assign sig_a = {|a.exp, a.mant};
	assign sig_b = {|b.exp, b.mant};

	assign product   = sig_a * sig_b;
	assign prod_hi   = product[PW-1];
	assign prod_norm = prod_hi ? product : product << 1;

	// round half up, next bit below the kept mantissa
	assign mant_rnd = {1'b0, prod_norm[PW-2 -: MANT_W]} + prod_norm[PW-2-MANT_W];

	// ea + eb - bias, plus normalize and round carries
	assign exp_calc = XW'(a.exp) + XW'(b.exp) - XW'(EXP_BIAS) + XW'(prod_hi) +
		XW'(mant_rnd[MANT_W]);

	always_comb begin
		prod_next      = '0;
		flags_next     = '0;
		prod_next.sign = a.sign ^ b.sign;
		if (special) begin
			prod_next.is_zero    = 1'b1;
			flags_next.exception = 1'b1;
		end else if (a_zero || b_zero) begin
			prod_next.is_zero = 1'b1;
		end else if (exp_calc >= EXP_MAX) begin
			// infinity, the add stage ignores c
			prod_next.exp       = XW'(EXP_MAX);
			prod_next.sig       = {1'b1, {MANT_W{1'b0}}};
			flags_next.overflow = 1'b1;
		end else if (exp_calc <= 0) begin
			// flushed to signed zero
			prod_next.is_zero    = 1'b1;
			flags_next.underflow = 1'b1;
		end else begin
			// round carry already left the mantissa at zero
			prod_next.exp = exp_calc;
			prod_next.sig = {1'b1, mant_rnd[MANT_W-1:0]};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mul_flags <= '0;
		end else if (load_mul) begin
			mul_flags <= flags_next;
		end
	end

	// datapath payload
	always_ff @(posedge clk) begin
		if (load_mul) begin
			prod  <= prod_next;
			c_reg <= operands.c;
		end
	end

	a_prod_hidden: assert property (@(posedge clk) disable iff (!arst_n)
		load_mul |=> (prod.is_zero || prod.sig[SIG_W-1]))
		else $error("non-zero product registered without hidden bit");

endmodule

// ==== source/mac_handshake.sv ====
//////////////////////////////////////////////////////////////////////
// four-phase req/ack sequencer for the two MAC stages
// requester must keep req and operands stable until ack is seen high
//////////////////////////////////////////////////////////////////////
module mac_handshake (
	input  logic clk,
	input  logic arst_n,
	input  logic req,
	output logic load_mul,
	output logic load_add,
	output logic ack
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_MUL,
		S_ADD,
		S_DONE
	} state_t;

	state_t state;
	state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: if (req) state_next = S_MUL;
			// product registered, addend path next
			S_MUL: state_next = S_ADD;
			S_ADD: state_next = S_DONE;
			// hold ack until the requester lets go
			S_DONE: if (!req) state_next = S_IDLE;
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			ack   <= 1'b0;
		end else begin
			state <= state_next;
			ack   <= (state_next == S_DONE);
		end
	end

	// mul stage samples on the same edge that sees req in idle
	assign load_mul = (state == S_IDLE) && req;
	assign load_add = (state == S_MUL);

	// ack only answers a request still held on the edge that raised it
	a_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req))
		else $error("ack rose without req held");

	a_one_load: assert property (@(posedge clk) disable iff (!arst_n)
		!(load_mul && load_add))
		else $error("both stage loads active in one cycle");

endmodule

// ==== include/fp_mac_model.svh ====
//////////////////////////////////////////////////////////////////////
// behavioral fp16 MAC model for the testbench
// expects fp_mac_pkg imported by the including module
// exp 0 reads as zero and exp 31 anywhere gives +0 with exception
//////////////////////////////////////////////////////////////////////
`ifndef FP_MAC_MODEL_SVH
`define FP_MAC_MODEL_SVH

function automatic fp16_t pack_fp16(logic sign, int exp, int unsigned sig);
	fp16_t f;
	f.sign = sign;
	f.exp  = EXP_W'(exp);
	f.mant = MANT_W'(sig);
	return f;
endfunction

function automatic void model_mac(input mac_operands_t op, output fp16_t res,
	output mac_flags_t flg);
	int          pe, ce, xe, e, d;
	int unsigned p, ps, cs, xs, ys, s;
	logic        psign, pzero, xsign, ysign;
	res   = '0;
	flg   = '0;
	pe    = 0;
	ps    = 0;
	if (op.a.exp == EXP_MAX || op.b.exp == EXP_MAX || op.c.exp == EXP_MAX) begin
		flg.exception = 1'b1;
		return;
	end
	psign = op.a.sign ^ op.b.sign;
	pzero = (op.a.exp == 0) || (op.b.exp == 0);
	// product with normalize and round half up
	if (!pzero) begin
		p  = {1'b1, op.a.mant} * {1'b1, op.b.mant};
		pe = int'(op.a.exp) + int'(op.b.exp) - EXP_BIAS;
		if (p[2*SIG_W-1]) pe++;
		else p = p << 1;
		ps = ((p >> SIG_W) & ((1 << MANT_W) - 1)) + ((p >> MANT_W) & 1);
		if (ps == (1 << MANT_W)) begin
			pe++;
			ps = 0;
		end
		ps = ps + (1 << MANT_W);
		if (pe >= EXP_MAX) begin
			res = pack_fp16(psign, EXP_MAX, 0);
			flg.overflow = 1'b1;
			return;
		end
		if (pe <= 0) begin
			pzero = 1'b1;
			flg.underflow = 1'b1;
		end
	end
	// zero terms
	if (pzero && op.c.exp == 0) begin
		res = pack_fp16(psign, 0, 0);
		return;
	end
	if (pzero) begin
		res = op.c;
		return;
	end
	if (op.c.exp == 0) begin
		res = pack_fp16(psign, pe, ps);
		return;
	end
	// swap by magnitude with a tie keeping the product as x
	ce = op.c.exp;
	cs = {1'b1, op.c.mant};
	if (pe > ce || (pe == ce && ps >= cs)) begin
		xe    = pe;
		xs    = ps;
		xsign = psign;
		ys    = cs;
		ysign = op.c.sign;
		d     = pe - ce;
	end else begin
		xe    = ce;
		xs    = cs;
		xsign = op.c.sign;
		ys    = ps;
		ysign = psign;
		d     = ce - pe;
	end
	ys = (d >= SIG_W + 1) ? 0 : ys >> d;
	e  = xe;
	if (xsign == ysign) begin
		s = xs + ys;
		if (s >= (1 << SIG_W)) begin
			s = s >> 1;
			e++;
		end
		if (e >= EXP_MAX) begin
			res = pack_fp16(xsign, EXP_MAX, 0);
			flg.overflow = 1'b1;
			return;
		end
	end else begin
		s = xs - ys;
		if (s == 0) return;
		while (s < (1 << MANT_W)) begin
			s = s << 1;
			e--;
		end
		if (e <= 0) begin
			res = pack_fp16(xsign, 0, 0);
			flg.underflow = 1'b1;
			return;
		end
	end
	res = pack_fp16(xsign, e, s);
endfunction

`endif

// ==== tests/tb_fp_mac.sv ====
//////////////////////////////////////////////////////////////////////
// fp16 MAC testbench with one request in flight
// req rises only after ack has fallen
// expected values come from the behavioral model in include/
//////////////////////////////////////////////////////////////////////
module tb_fp_mac
	import fp_mac_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 4;
	localparam int N_DIR        = 19;
	localparam int N_RAND       = 300;
	localparam int N_OPS        = N_DIR + N_RAND;
	// cycles to wait for ack to move before giving up
	localparam int ACK_WAIT     = 8;

	// directed vectors packed as a_b_c
	localparam logic [47:0] DIRECTED [N_DIR] = '{
		48'h3c00_3c00_3c00,
		48'h3c01_3c01_0000,
		48'h3e00_3e00_3c00,
		48'h3c00_3c00_bc00,
		48'h3c01_3c00_bc00,
		48'h0401_3c00_8400,
		48'h0400_0400_3c00,
		48'h7800_7800_3c00,
		48'hf800_7800_3c00,
		48'h7bff_3c00_7bff,
		48'h7c00_3c00_3c00,
		48'h3c00_7e00_3c00,
		48'h3c00_3c00_fc00,
		48'h0000_3c00_4000,
		48'h3c00_8000_c200,
		48'h4000_4200_0000,
		48'h8000_3c00_0000,
		48'h3c00_3c00_7000,
		48'hbc00_3c00_7000
	};

	logic          clk;
	logic          arst_n;
	logic          req;
	mac_operands_t operands;
	logic          ack;
	fp16_t         result;
	mac_flags_t    flags;

	// expected response of the op in flight
	fp16_t         exp_res;
	mac_flags_t    exp_flg;

	logic [15:0]   lfsr = 16'd90;
	int            value_errors = 0;
	int            protocol_errors = 0;
	int            ops_done = 0;

	`include "fp_mac_model.svh"

	fp_mac u_fp_mac (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.operands (operands),
		.ack      (ack),
		.result   (result),
		.flags    (flags)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// random source
	//////////////////////////////////////////////////////////////////////

	// 16-bit galois with taps at 16 14 13 11
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// a and b exps 8..23 keep the product near range
	// c takes any normal exponent
	function automatic mac_operands_t rand_operands();
		mac_operands_t op;
		op.a.sign = 1'(take_bits(1));
		op.a.exp  = 5'd8 + 5'(take_bits(4));
		op.a.mant = 10'(take_bits(10));
		op.b.sign = 1'(take_bits(1));
		op.b.exp  = 5'd8 + 5'(take_bits(4));
		op.b.mant = 10'(take_bits(10));
		op.c.sign = 1'(take_bits(1));
		op.c.exp  = 5'(take_bits(5));
		op.c.mant = 10'(take_bits(10));
		if (op.c.exp == 5'd0)
			op.c.exp = 5'd1;
		if (op.c.exp == 5'd31)
			op.c.exp = 5'd30;
		return op;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// requester side of the four-phase handshake
	//////////////////////////////////////////////////////////////////////

	task automatic run_op(input mac_operands_t op, input int hold);
		int waited;
		@(negedge clk);
		operands = op;
		model_mac(op, exp_res, exp_flg);
		req    = 1'b1;
		waited = 0;
		while (ack !== 1'b1 && waited < ACK_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (ack !== 1'b1) begin
			protocol_errors++;
			$display("handshake: no ack within %0d cycles of req, time %0t",
				ACK_WAIT, $time);
		end
		// operands wander under back-pressure once ack is seen
		repeat (hold) begin
			operands = rand_operands();
			@(negedge clk);
		end
		req    = 1'b0;
		waited = 0;
		while (ack !== 1'b0 && waited < ACK_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (ack !== 1'b0) begin
			protocol_errors++;
			$display("handshake: ack stuck high after req dropped, time %0t", $time);
		end
		ops_done++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// ack lands exactly three sampled edges after req rose
	a_ack_latency: assert property (@(posedge clk) disable iff (!arst_n)
		($past(req, 3) && !$past(req, 4)) |-> (ack && !$past(ack)))
		else begin
			protocol_errors++;
			$display("handshake: ack not raised two edges after req was taken, time %0t",
				$time);
		end

	a_ack_no_early: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> ($past(req, 3) && !$past(req, 4)))
		else begin
			protocol_errors++;
			$display("handshake: ack rose at the wrong time, time %0t", $time);
		end

	a_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
		(ack && !req) |=> !ack)
		else begin
			protocol_errors++;
			$display("handshake: ack did not fall after req went low, time %0t", $time);
		end

	a_ack_held: assert property (@(posedge clk) disable iff (!arst_n)
		(ack && req) |=> ack)
		else begin
			protocol_errors++;
			$display("handshake: ack dropped while req still high, time %0t", $time);
		end

	// result against the model on every ack
	a_result: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> ((result == exp_res) && (flags == exp_flg)))
		else begin
			value_errors++;
			$display("** Error at %0t: result %h flags %b, expected %h flags %b",
				$time, result, flags, exp_res, exp_flg);
		end

	// nothing moves while ack is up
	a_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(ack && $past(ack)) |-> ($stable(result) && $stable(flags)))
		else begin
			value_errors++;
			$display("** Error at %0t: result or flags changed while ack high", $time);
		end

	//////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		arst_n   = 1'b0;
		req      = 1'b0;
		operands = '0;
		exp_res  = '0;
		exp_flg  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		a_reset_idle: assert (ack === 1'b0 && result === '0 && flags === '0)
			else begin
				value_errors++;
				$display("** Error at %0t: ack, result or flags not zero after reset",
					$time);
			end
		for (int i = 0; i < N_DIR; i++)
			run_op(DIRECTED[i], i % 3);
		for (int i = 0; i < N_RAND; i++)
			run_op(rand_operands(), int'(take_bits(2)));
		@(negedge clk);
		$display("ops %0d, value errors %0d, handshake errors %0d",
			ops_done, value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// budget of 12 cycles per op after reset
	initial begin
		#((RESET_CYCLES + N_OPS * 12) * CLK_PERIOD);
		$display("timeout: run stalled after %0d of %0d ops, value errors %0d, handshake errors %0d",
			ops_done, N_OPS, value_errors, protocol_errors);
		$display("Regression failed");
		$finish;
	end

endmodule
